// ==== hdl/scroll_pkg.sv ====
// Shared types and register map of the scroll control block, imported by each RTL module
package scroll_pkg;

    // One CPU write on the character RAM bus, held stable while req is high
    typedef struct packed {
        logic [10:0] addr;    // word address, bits 11..1
        logic [15:0] data;
        logic [1:0]  dsn;     // active low byte strobes, bit 1 is the upper byte
    } cpu_wr_t;

    // Decoded write handed from the decoder to the register file
    typedef struct packed {
        logic        hit;
        logic [2:0]  idx;
        logic [15:0] data;
        logic [1:0]  dsn;
        logic        valid;
        logic [3:0]  rsvd;
    } reg_sel_t;

    // Active scroll state of one tilemap layer
    typedef struct packed {
        logic [3:0][3:0] pages;   // one page per quadrant, indexed by {y[8], x[9]}
        logic [15:0]     hpos;
        logic [15:0]     vpos;
    } layer_scroll_t;

    // Raw screen position from the video timing
    typedef struct packed {
        logic [9:0] h;
        logic [7:0] v;
    } scr_pos_t;

    // Tilemap address of one layer
    typedef struct packed {
        logic [3:0] page;
        logic [4:0] row;
        logic [5:0] col;
    } tile_addr_t;

    // Byte offsets inside the 512-byte register window
    localparam logic [8:0] REG_S1_PG_FL = 9'h08e;
    localparam logic [8:0] REG_S1_PG_NF = 9'h09e;
    localparam logic [8:0] REG_S2_PG_FL = 9'h08c;
    localparam logic [8:0] REG_S2_PG_NF = 9'h09c;
    localparam logic [8:0] REG_S1_VPOS  = 9'h124;
    localparam logic [8:0] REG_S2_VPOS  = 9'h126;
    localparam logic [8:0] REG_S1_HPOS  = 9'h1f8;
    localparam logic [8:0] REG_S2_HPOS  = 9'h1fa;

    // Register file slots
    localparam logic [2:0] IDX_S1_PG_FL = 3'd0;
    localparam logic [2:0] IDX_S1_PG_NF = 3'd1;
    localparam logic [2:0] IDX_S2_PG_FL = 3'd2;
    localparam logic [2:0] IDX_S2_PG_NF = 3'd3;
    localparam logic [2:0] IDX_S1_VPOS  = 3'd4;
    localparam logic [2:0] IDX_S2_VPOS  = 3'd5;
    localparam logic [2:0] IDX_S1_HPOS  = 3'd6;
    localparam logic [2:0] IDX_S2_HPOS  = 3'd7;

endpackage

// ==== hdl/mmr_decode.sv ====
// CPU write decoder, checks the register window, picks the register and answers req with ack
module mmr_decode import scroll_pkg::*; #(
    parameter logic [2:0] WIN_BASE = 3'd7
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req,
    input  cpu_wr_t  wr,
    output logic     ack,
    output reg_sel_t sel
);

    logic       new_req;
    logic       in_win;
    logic [8:0] offset;
    logic       known;
    logic [2:0] idx;
    logic       valid_q;
    logic       hit_q;
    logic [2:0] idx_q;
    logic [15:0] data_q;
    logic [1:0] dsn_q;

    // A request is new only while the previous one has been fully released
    assign new_req = req && !ack;

    // Bits 11..9 select the window
    assign in_win = (wr.addr[10:8] == WIN_BASE);

    // Byte offset of the word inside the window
    assign offset = {wr.addr[7:0], 1'b0};

    // Offset to register slot
    always_comb begin
        known = 1'b1;
        idx   = IDX_S1_PG_FL;
        case (offset)
            REG_S1_PG_FL: idx = IDX_S1_PG_FL;
            REG_S1_PG_NF: idx = IDX_S1_PG_NF;
            REG_S2_PG_FL: idx = IDX_S2_PG_FL;
            REG_S2_PG_NF: idx = IDX_S2_PG_NF;
            REG_S1_VPOS:  idx = IDX_S1_VPOS;
            REG_S2_VPOS:  idx = IDX_S2_VPOS;
            REG_S1_HPOS:  idx = IDX_S1_HPOS;
            REG_S2_HPOS:  idx = IDX_S2_HPOS;
            default:      known = 1'b0;
        endcase
    end

    // Four-phase handshake
    // ack rises with the valid pulse and drops one edge after req goes low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack     <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= new_req;
            if (new_req) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;
            end
        end
    end

    // Write payload, captured once per request
    // Misses and all-strobes-high writes are acked but carry no hit
    always_ff @(posedge clk) begin
        if (new_req) begin
            hit_q  <= in_win && known && (wr.dsn != 2'b11);
            idx_q  <= idx;
            data_q <= wr.data;
            dsn_q  <= wr.dsn;
        end
    end

    assign sel = '{hit: hit_q, idx: idx_q, data: data_q, dsn: dsn_q,
                   valid: valid_q, rsvd: 4'h0};

endmodule

// ==== hdl/scroll_regs.sv ====
// Scroll register file with byte-lane writes and the flip-dependent page word per layer
module scroll_regs import scroll_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          flip,
    input  reg_sel_t      sel,
    output layer_scroll_t lay1,
    output layer_scroll_t lay2
);

    // Eight 16-bit registers, slot numbers from the package
    logic [7:0][15:0] regs;

    // Active page words, one per layer
    logic [3:0][3:0] pg1_q;
    logic [3:0][3:0] pg2_q;

    // Lane merge
    // A high strobe keeps the old byte of that lane
    function automatic logic [15:0] byte_merge(
        input logic [15:0] old,
        input logic [15:0] din,
        input logic [1:0]  dsn
    );
        logic [7:0] hi;
        logic [7:0] lo;
        hi = dsn[1] ? old[15:8] : din[15:8];
        lo = dsn[0] ? old[7:0] : din[7:0];
        return {hi, lo};
    endfunction

    // Register update
    // Decode has already qualified hit against window, offset and strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '0;
        end else if (sel.valid && sel.hit) begin
            regs[sel.idx] <= byte_merge(regs[sel.idx], sel.data, sel.dsn);
        end
    end

    // Page word selection
    // Follows flip one cycle later, and a page write one cycle after the register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pg1_q <= '0;
            pg2_q <= '0;
        end else begin
            pg1_q <= flip ? regs[IDX_S1_PG_FL] : regs[IDX_S1_PG_NF];
            pg2_q <= flip ? regs[IDX_S2_PG_FL] : regs[IDX_S2_PG_NF];
        end
    end

    // Layer 1 state
    assign lay1 = '{
        pages: pg1_q,
        hpos:  regs[IDX_S1_HPOS],
        vpos:  regs[IDX_S1_VPOS]
    };

    // Layer 2 state
    assign lay2 = '{
        pages: pg2_q,
        hpos:  regs[IDX_S2_HPOS],
        vpos:  regs[IDX_S2_VPOS]
    };

    // Scroll words reach the layers straight from the registers
    // so a scroll write shows up one edge before a page write does

endmodule

// ==== hdl/scroll_addr.sv ====
// Two-stage tilemap address generator, one screen position in per cycle, result two cycles later
module scroll_addr import scroll_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  scr_pos_t      pos,
    input  layer_scroll_t lay1,
    input  layer_scroll_t lay2,
    output tile_addr_t    tile1,
    output tile_addr_t    tile2
);

    // Scrolled point on the 1024x512 plane with the page word of the same cycle
    typedef struct packed {
        logic [9:0]      x;
        logic [8:0]      y;
        logic [3:0][3:0] pages;
    } stage_t;

    stage_t lay1_q;
    stage_t lay2_q;

    // Stage one math
    // Widths give the wrap at 1024 and 512 for free
    function automatic stage_t scroll_pt(input scr_pos_t p, input layer_scroll_t l);
        stage_t s;
        s.x     = p.h + l.hpos[9:0];
        s.y     = {1'b0, p.v} + l.vpos[8:0];
        s.pages = l.pages;
        return s;
    endfunction

    // Stage two slicing
    // Quadrant is {y[8], x[9]}, tiles are 8x8 pixels
    function automatic tile_addr_t to_tile(input stage_t s);
        tile_addr_t t;
        t.page = s.pages[{s.y[8], s.x[9]}];
        t.row  = s.y[7:3];
        t.col  = s.x[8:3];
        return t;
    endfunction

    // Stage one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lay1_q <= '0;
            lay2_q <= '0;
        end else begin
            lay1_q <= scroll_pt(pos, lay1);
            lay2_q <= scroll_pt(pos, lay2);
        end
    end

    // Stage two
    // Uses the page word carried along, not the live one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tile1 <= '0;
            tile2 <= '0;
        end else begin
            tile1 <= to_tile(lay1_q);
            tile2 <= to_tile(lay2_q);
        end
    end

endmodule

// ==== hdl/scroll_sys.sv ====
// Scroll control top level, ties CPU decode, scroll registers and tile address pipeline together
module scroll_sys import scroll_pkg::*; #(
    parameter logic [2:0] WIN_BASE = 3'd7
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       flip,
    // CPU write side
    input  cpu_wr_t    wr,
    input  logic       req,
    output logic       ack,
    // Video side
    input  scr_pos_t   pos,
    output tile_addr_t tile1,
    output tile_addr_t tile2
);

    reg_sel_t      sel;
    layer_scroll_t lay1;
    layer_scroll_t lay2;

    // Address decode and handshake
    mmr_decode #(
        .WIN_BASE (WIN_BASE)
    ) u_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .wr     (wr),
        .ack    (ack),
        .sel    (sel)
    );

    // Register file
    scroll_regs u_regs (
        .clk    (clk),
        .arst_n (arst_n),
        .flip   (flip),
        .sel    (sel),
        .lay1   (lay1),
        .lay2   (lay2)
    );

    // Tile address pipeline
    scroll_addr u_addr (
        .clk    (clk),
        .arst_n (arst_n),
        .pos    (pos),
        .lay1   (lay1),
        .lay2   (lay2),
        .tile1  (tile1),
        .tile2  (tile2)
    );

endmodule

// ==== sim/scroll_sys_chk.sv ====
// Handshake and reset assertions that the testbench binds into the scroll top level
module scroll_sys_chk import scroll_pkg::*; (
    input logic     clk,
    input logic     arst_n,
    input logic     req,
    input logic     ack,
    input reg_sel_t sel
);

    timeunit 1ns;
    timeprecision 100ps;

    // Running count of assertion failures
    int err_count = 0;

    // ack only rises in answer to req seen on the edge before
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(ack) |-> $past(req)
    ) else begin
        $error("ack rose while req was low");
        err_count++;
    end

    // Once given, ack is held for as long as req stays high
    ack_holds: assert property (
        @(posedge clk) disable iff (!arst_n) (ack && req) |=> ack
    ) else begin
        $error("ack dropped while req was still high");
        err_count++;
    end

    // One valid per request
    valid_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) sel.valid |=> !sel.valid
    ) else begin
        $error("sel.valid lasted more than one cycle");
        err_count++;
    end

    // No ack while held in reset
    ack_in_reset: assert property (
        @(posedge clk) !arst_n |-> !ack
    ) else begin
        $error("ack high during reset");
        err_count++;
    end

endmodule

// ==== sim/scroll_sys_tb.sv ====
// Replays the scroll vectors through CPU writes and position probes and checks tile addresses
module scroll_sys_tb import scroll_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_VEC = 64;

    logic       clk;
    logic       arst_n;
    logic       flip;
    logic       req;
    logic       ack;
    cpu_wr_t    wr;
    scr_pos_t   pos;
    tile_addr_t tile1;
    tile_addr_t tile2;

    // One entry per vector line
    logic [7:0]  v_kind [MAX_VEC];
    string       v_name [MAX_VEC];
    logic [11:0] v_addr [MAX_VEC];
    logic [15:0] v_data [MAX_VEC];
    logic [1:0]  v_dsn  [MAX_VEC];
    logic        v_flip [MAX_VEC];
    scr_pos_t    v_pos  [MAX_VEC];
    tile_addr_t  v_exp1 [MAX_VEC];
    tile_addr_t  v_exp2 [MAX_VEC];
    int          n_vec;
    logic        loaded;

    // Expected results still inside the address pipeline
    tile_addr_t pend1 [$];
    tile_addr_t pend2 [$];

    integer seed;
    logic   ok;
    string  test_name;
    logic   in_test;
    int     test_checks;
    int     test_errs;
    int     n_checks;
    int     n_errs;
    int     n_pass;
    int     n_fail;

    scroll_sys #(
        .WIN_BASE (3'd7)
    ) u_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .flip   (flip),
        .wr     (wr),
        .req    (req),
        .ack    (ack),
        .pos    (pos),
        .tile1  (tile1),
        .tile2  (tile2)
    );

    // Handshake and reset assertions inside the DUT
    bind scroll_sys scroll_sys_chk u_chk (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .ack    (ack),
        .sel    (sel)
    );

    // 50 MHz clock
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Step n edges and land 2 ns past the last one
    task automatic wait_cycles(input int n);
        if (n > 0) begin
            repeat (n) @(posedge clk);
            #2;
        end
    endtask

    // Random idle time between handshake phases
    function automatic int rand_gap();
        return $unsigned($random(seed)) % 4;
    endfunction

    // Compare one value and log a mismatch against the running test
    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        test_checks++;
        n_checks++;
        if (got !== exp) begin
            test_errs++;
            n_errs++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // One summary line for the test that just ended
    task automatic end_test();
        if (in_test) begin
            if (test_errs == 0) begin
                n_pass++;
                $display("test %s: %0d checks ok", test_name, test_checks);
            end else begin
                n_fail++;
                $display("test %s: %0d checks, %0d mismatches",
                         test_name, test_checks, test_errs);
            end
            in_test = 1'b0;
        end
    endtask

    task automatic begin_test(input string name);
        end_test();
        test_name   = name;
        test_checks = 0;
        test_errs   = 0;
        in_test     = 1'b1;
    endtask

    // Compare the tile outputs against the oldest probe in flight
    task automatic check_oldest();
        tile_addr_t e1;
        tile_addr_t e2;
        e1 = pend1.pop_front();
        e2 = pend2.pop_front();
        check("tile1.page", tile1.page, e1.page);
        check("tile1.row", tile1.row, e1.row);
        check("tile1.col", tile1.col, e1.col);
        check("tile2.page", tile2.page, e2.page);
        check("tile2.row", tile2.row, e2.row);
        check("tile2.col", tile2.col, e2.col);
    endtask

    // Let every probe in flight reach the outputs
    task automatic drain();
        while (pend1.size() > 0) begin
            wait_cycles(1);
            check_oldest();
        end
    endtask

    // P settles flip first and S follows the previous probe on the next cycle
    task automatic probe(input int i, input logic stream);
        if (!stream) begin
            drain();
            flip = v_flip[i];
            wait_cycles(3);
        end
        pos = v_pos[i];
        pend1.push_back(v_exp1[i]);
        pend2.push_back(v_exp2[i]);
        wait_cycles(1);
        // Two in flight means the older one is at the outputs now
        if (pend1.size() == 2) begin
            check_oldest();
        end
    endtask

    // Full four-phase write with random gaps between phases
    task automatic cpu_write(input int i);
        drain();
        wait_cycles(rand_gap());
        wr.addr = v_addr[i][11:1];
        wr.data = v_data[i];
        wr.dsn  = v_dsn[i];
        req     = 1'b1;
        while (ack !== 1'b1) wait_cycles(1);
        wait_cycles(rand_gap());
        req = 1'b0;
        while (ack !== 1'b0) wait_cycles(1);
    endtask

    // Parse T, W, P and S lines and skip comment lines
    task automatic load_vectors(output logic good);
        integer           fd;
        integer           code;
        logic [8*32-1:0]  tok;
        logic [8*128-1:0] rest;
        logic [11:0]      a;
        logic [15:0]      d;
        logic [1:0]       s;
        int               f;
        int               ph;
        int               pv;
        int               p1;
        int               r1;
        int               c1;
        int               p2;
        int               r2;
        int               c2;
        logic             done;
        n_vec = 0;
        good  = 1'b1;
        done  = 1'b0;
        fd    = $fopen("sim/scroll_sys_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vectors file sim/scroll_sys_vectors.txt");
            good = 1'b0;
            done = 1'b1;
        end
        while (!done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else if (tok == "#") begin
                code = $fgets(rest, fd);
            end else if (n_vec == MAX_VEC) begin
                $display("the vectors file has more lines than the testbench can hold");
                good = 1'b0;
                done = 1'b1;
            end else if (tok == "T") begin
                code = $fscanf(fd, "%s", tok);
                v_kind[n_vec] = "T";
                v_name[n_vec] = string'(tok);
                n_vec++;
            end else if (tok == "W") begin
                code = $fscanf(fd, "%h %h %h", a, d, s);
                v_kind[n_vec] = "W";
                v_addr[n_vec] = a;
                v_data[n_vec] = d;
                v_dsn[n_vec]  = s;
                n_vec++;
                if (code != 3) begin
                    $display("a write line in the vectors file is incomplete");
                    good = 1'b0;
                    done = 1'b1;
                end
            end else if (tok == "P" || tok == "S") begin
                code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d",
                               f, ph, pv, p1, r1, c1, p2, r2, c2);
                v_kind[n_vec] = tok[7:0];
                v_flip[n_vec] = f[0];
                v_pos[n_vec]  = '{h: ph[9:0], v: pv[7:0]};
                v_exp1[n_vec] = '{page: p1[3:0], row: r1[4:0], col: c1[5:0]};
                v_exp2[n_vec] = '{page: p2[3:0], row: r2[4:0], col: c2[5:0]};
                n_vec++;
                if (code != 9) begin
                    $display("a probe line in the vectors file is incomplete");
                    good = 1'b0;
                    done = 1'b1;
                end
            end else begin
                $display("the vectors file has a line of unknown kind");
                good = 1'b0;
                done = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (good && n_vec == 0) begin
            $display("the vectors file holds no vectors");
            good = 1'b0;
        end
    endtask

    // Walk the vector list in file order
    task automatic run_vectors();
        int i;
        for (i = 0; i < n_vec; i++) begin
            case (v_kind[i])
                "T": begin
                    drain();
                    begin_test(v_name[i]);
                end
                "W": cpu_write(i);
                "P": probe(i, 1'b0);
                "S": probe(i, 1'b1);
            endcase
        end
        drain();
    endtask

    initial begin
        arst_n  = 1'b0;
        flip    = 1'b0;
        req     = 1'b0;
        wr      = '0;
        pos     = '0;
        seed    = 32'h979a1534;
        loaded  = 1'b0;
        in_test = 1'b0;
        n_checks = 0;
        n_errs   = 0;
        n_pass   = 0;
        n_fail   = 0;
        load_vectors(ok);
        loaded = ok;
        if (ok) begin
            repeat (8) @(posedge clk);
            #2;
            // Outputs while still in reset
            begin_test("reset_values");
            check("ack", ack, 16'h0);
            check("tile1", tile1, 16'h0);
            check("tile2", tile2, 16'h0);
            arst_n = 1'b1;
            wait_cycles(1);
            run_vectors();
        end else begin
            n_errs++;
        end
        end_test();
        // Failures of the bound handshake assertions
        if (u_dut.u_chk.err_count != 0) begin
            $display("the handshake assertions failed %0d times", u_dut.u_chk.err_count);
            n_errs += u_dut.u_chk.err_count;
        end
        $display("%0d tests passed, %0d tests with mismatches, %0d checks, %0d errors",
                 n_pass, n_fail, n_checks, n_errs);
        if (n_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog allows 40 cycles per vector line
    initial begin
        wait (loaded === 1'b1);
        #(n_vec * 40 * 20);
        $display("run timed out");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== sim/scroll_sys_vectors.txt ====
# W byte_addr data dsn (hex), dsn bit 1 strobes the upper byte, active low
# P flip h v page1 row1 col1 page2 row2 col2 (decimal), S is a P on the next cycle
T reset_state
P 0 37 21 0 2 4 0 2 4
T full_word
# hpos and vpos of both layers, layer 2 wraps in x and in y
W FF8 0123 0
W F24 0045 0
W FFA 03F0 0
W F26 01F8 0
P 0 37 21 0 11 41 0 1 2
P 0 1000 255 0 8 33 0 30 59
T byte_lane
W FF8 AB77 2
W F26 0200 1
P 0 37 21 0 11 51 0 1 2
W F24 01AA 1
P 0 600 100 0 21 57 0 11 9
T page_select
W E8E 4321 0
W E9E 8765 0
W E8C CBA9 0
W E9C 0FED 0
W FF8 0000 0
W F24 0080 0
W FFA 0200 0
W F26 0180 0
P 0 100 0 5 16 12 0 16 12
P 0 600 0 6 16 11 15 16 11
P 0 100 200 7 9 12 14 9 12
P 0 600 200 8 9 11 13 9 11
P 1 100 0 1 16 12 12 16 12
P 1 600 0 2 16 11 11 16 11
P 1 100 200 3 9 12 10 9 12
P 1 600 200 4 9 11 9 9 11
T ignored_writes
# outside the window, unknown offset, then both strobes high
W DF8 1111 0
W E90 2222 0
W FF8 3333 3
W E8E 0000 3
P 1 600 200 4 9 11 9 9 11
P 0 100 0 5 16 12 0 16 12
T back_to_back
P 1 100 0 1 16 12 12 16 12
S 1 600 0 2 16 11 11 16 11
S 1 100 200 3 9 12 10 9 12
S 1 600 200 4 9 11 9 9 11
S 1 0 0 1 16 0 12 16 0
S 1 1023 255 4 15 63 9 15 63

// ==== scroll_sys.f ====
hdl/scroll_pkg.sv
hdl/mmr_decode.sv
hdl/scroll_regs.sv
hdl/scroll_addr.sv
hdl/scroll_sys.sv
sim/scroll_sys_chk.sv
sim/scroll_sys_tb.sv
